// ==== list.f ====
rtl/dcache_pkg.sv
rtl/dcache_req_stage.sv
rtl/dcache_way.sv
rtl/dcache_resp_sel.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
test/mem_model.sv
test/dcache_checker.sv
test/tb_dcache.sv

// ==== rtl/dcache_ctrl.sv ====
// cache controller FSM
// per-set lru bits, cpu handshake, memory read and write channels,
// fill and store writes into the ways
`timescale 1ns/1ps

module dcache_ctrl #(
  parameter  int INDEX_BITS = 8,
  localparam int TAG_BITS   = 32 - dcache_pkg::OFFSET_BITS - INDEX_BITS
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  dcache_pkg::cpu_req_t            cpu_req,
  input  dcache_pkg::cpu_req_t            req_q,
  input  logic [31:0]                     store_word,
  input  logic [3:0]                      store_strb,
  input  logic                            hit_any,
  input  logic                            hit_way,
  input  logic [31:0]                     load_word,
  input  dcache_pkg::line_t               victim_line,
  input  logic [TAG_BITS-1:0]             victim_tag,
  input  logic                            victim_dirty,
  input  logic                            mem_rd_rdy,
  input  logic                            mem_ret_valid,
  input  dcache_pkg::line_t               mem_ret_data,
  input  logic                            mem_wr_rdy,
  input  logic                            mem_wr_done,
  output logic                            accept,
  output logic                            addr_ok,
  output logic                            data_ok,
  output logic [31:0]                     rdata,
  output logic                            victim_way,
  output logic [dcache_pkg::NUM_WAYS-1:0] way_sel,
  output dcache_pkg::way_wr_t             wr,
  output logic                            mem_rd_req,
  output logic [31:0]                     mem_rd_addr,
  output logic                            mem_wr_req,
  output logic [31:0]                     mem_wr_addr,
  output dcache_pkg::line_t               mem_wr_data
);
  import dcache_pkg::*;

  localparam int SETS = 1 << INDEX_BITS;

  typedef enum logic [2:0] {
    idle, lookup, store, miss_dirty, writeback, miss_clean, refill
  } state_e;

  state_e                state;
  state_e                state_nxt;
  logic                  replay;     // refilled request still owes its lookup
  logic [SETS-1:0]       lru;        // way not used last
  logic                  hit_way_q;
  logic                  can_accept;
  logic                  fill_now;
  logic [INDEX_BITS-1:0] req_index;
  logic [TAG_BITS-1:0]   req_tag;
  cache_addr_u           req_addr;

  assign req_addr.raw = req_q.addr;
  assign req_index    = req_q.addr[OFFSET_BITS +: INDEX_BITS];
  assign req_tag      = req_q.addr[31 -: TAG_BITS];

  // only a load hit lets the next request in during lookup
  assign can_accept = (state == idle && !replay) ||
                      (state == lookup && hit_any && !req_q.op);
  assign accept     = cpu_req.valid & can_accept;
  assign addr_ok    = accept;
  assign data_ok    = (state == lookup) & hit_any;
  assign rdata      = load_word;
  assign victim_way = lru[req_index];
  assign fill_now   = (state == refill) & mem_ret_valid;

  always_comb begin
    state_nxt = state;
    unique case (state)
      idle:       if (accept || replay) state_nxt = lookup;
      lookup: begin
        if (!hit_any) begin
          state_nxt = victim_dirty ? miss_dirty : miss_clean;
        end else if (req_q.op) begin
          state_nxt = store;
        end else if (!accept) begin
          state_nxt = idle;
        end
      end
      store:      state_nxt = idle;
      miss_dirty: if (mem_wr_rdy) state_nxt = writeback;
      writeback:  if (mem_wr_done) state_nxt = miss_clean;
      miss_clean: if (mem_rd_rdy) state_nxt = refill;
      refill:     if (mem_ret_valid) state_nxt = idle;  // replay from idle
      default:    state_nxt = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= idle;
      replay <= 1'b0;
      lru    <= '0;
    end else begin
      state <= state_nxt;
      if (fill_now) begin
        replay <= 1'b1;
      end else if (state == idle) begin
        replay <= 1'b0;
      end
      if (data_ok) begin
        lru[req_index] <= ~hit_way;
      end
    end
  end

  // way for the store cycle
  always_ff @(posedge clk) begin
    if (state == lookup) begin
      hit_way_q <= hit_way;
    end
  end

  always_comb begin
    wr          = '0;
    wr.index    = MAX_INDEX_BITS'(req_index);
    wr.tag      = TAG_FIELD_BITS'(req_tag);
    wr.word_sel = req_addr.f.offset[3:2];
    way_sel     = '0;
    if (fill_now) begin
      wr.en               = 1'b1;
      wr.fill             = 1'b1;
      wr.line             = mem_ret_data;
      way_sel[victim_way] = 1'b1;
    end else if (state == store) begin
      wr.en              = 1'b1;
      wr.line            = {WORDS_PER_LINE{store_word}};  // ways keep the strobed lanes
      wr.strb            = store_strb;
      wr.set_dirty       = 1'b1;
      way_sel[hit_way_q] = 1'b1;
    end
  end

  assign mem_rd_req  = (state == miss_clean);
  assign mem_rd_addr = {req_q.addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
  assign mem_wr_req  = (state == miss_dirty);
  assign mem_wr_addr = {victim_tag, req_index, {OFFSET_BITS{1'b0}}};
  assign mem_wr_data = victim_line;  // arrays hold still until the refill

endmodule

// ==== rtl/dcache_pkg.sv ====
// shared types and constants for the two-way data cache
// line geometry, cpu request, address view and the way write port
package dcache_pkg;

  localparam int OFFSET_BITS    = 4;  // 16-byte line
  localparam int WORDS_PER_LINE = 4;
  localparam int NUM_WAYS       = 2;  // one lru bit per set only covers two
  localparam int DEF_INDEX_BITS = 8;
  localparam int MAX_INDEX_BITS = 12; // widest index the write port carries
  localparam int TAG_FIELD_BITS = 32 - OFFSET_BITS;

  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } store_size_e;

  typedef logic [WORDS_PER_LINE-1:0][31:0] line_t;

  typedef struct packed {
    logic        valid;
    logic        op;    // 1 for a store
    logic [31:0] addr;
    store_size_e size;
    logic [31:0] wdata;
  } cpu_req_t;

  // address split at the default set count
  typedef struct packed {
    logic [31-OFFSET_BITS-DEF_INDEX_BITS:0] tag;
    logic [DEF_INDEX_BITS-1:0]              index;
    logic [OFFSET_BITS-1:0]                 offset;
  } addr_fields_t;

  typedef union packed {
    logic [31:0]  raw;
    addr_fields_t f;
  } cache_addr_u;

  // one write into a way, either a refill or a strobed word
  typedef struct packed {
    logic                      en;
    logic                      fill;
    logic [MAX_INDEX_BITS-1:0] index;
    logic [TAG_FIELD_BITS-1:0] tag;      // low tag bits only
    line_t                     line;
    logic [1:0]                word_sel;
    logic [3:0]                strb;
    logic                      set_dirty;
  } way_wr_t;

endpackage

// ==== rtl/dcache_req_stage.sv ====
// request register of the data cache
// lookup index select, store lane alignment and byte strobe
`timescale 1ns/1ps

module dcache_req_stage #(
  parameter int INDEX_BITS = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  dcache_pkg::cpu_req_t  cpu_req,
  input  logic                  accept,
  output dcache_pkg::cpu_req_t  req_q,
  output logic [INDEX_BITS-1:0] rd_index,
  output logic [31:0]           store_word,
  output logic [3:0]            store_strb
);
  import dcache_pkg::*;

  cache_addr_u req_addr;
  logic [4:0]  byte_shift;

  // held through a miss and the replayed lookup
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_q.valid <= 1'b0;
    end else if (accept) begin
      req_q <= cpu_req;
    end
  end

  assign req_addr.raw = req_q.addr;
  assign byte_shift   = {req_addr.f.offset[1:0], 3'b000};

  // new request reads the arrays in the cycle it is accepted
  assign rd_index = accept ? cpu_req.addr[OFFSET_BITS +: INDEX_BITS]
                           : req_q.addr[OFFSET_BITS +: INDEX_BITS];

  always_comb begin
    unique case (req_q.size)
      size_byte: begin
        store_word = {24'd0, req_q.wdata[7:0]} << byte_shift;
        store_strb = 4'b0001 << req_addr.f.offset[1:0];
      end
      size_half: begin
        if (req_addr.f.offset[1]) begin // upper halfword
          store_word = {req_q.wdata[15:0], 16'd0};
          store_strb = 4'b1100;
        end else begin
          store_word = {16'd0, req_q.wdata[15:0]};
          store_strb = 4'b0011;
        end
      end
      default: begin
        store_word = req_q.wdata;
        store_strb = 4'b1111;
      end
    endcase
  end

endmodule

// ==== rtl/dcache_resp_sel.sv ====
// response select across both ways
// load word from the hitting way, victim line, tag and dirty bit
`timescale 1ns/1ps

module dcache_resp_sel #(
  parameter  int INDEX_BITS = 8,
  localparam int TAG_BITS   = 32 - dcache_pkg::OFFSET_BITS - INDEX_BITS
) (
  input  logic [dcache_pkg::NUM_WAYS-1:0]               hit,
  input  dcache_pkg::line_t [dcache_pkg::NUM_WAYS-1:0]  lines,
  input  logic [dcache_pkg::NUM_WAYS-1:0][TAG_BITS-1:0] tags,
  input  logic [dcache_pkg::NUM_WAYS-1:0]               dirty,
  input  logic [1:0]                                    word_sel,
  input  logic                                          victim_way,
  output logic                                          hit_any,
  output logic                                          hit_way,
  output logic [31:0]                                   load_word,
  output dcache_pkg::line_t                             victim_line,
  output logic [TAG_BITS-1:0]                           victim_tag,
  output logic                                          victim_dirty
);
  import dcache_pkg::*;

  line_t hit_line;

  assign hit_any = |hit;
  assign hit_way = hit[1];  // both never hit at once

  assign hit_line  = lines[hit_way];
  assign load_word = hit_line[word_sel];

  // replacement candidate for writeback and refill
  assign victim_line  = lines[victim_way];
  assign victim_tag   = tags[victim_way];
  assign victim_dirty = dirty[victim_way];

endmodule

// ==== rtl/dcache_top.sv ====
// two-way set-associative write-back data cache
// request stage, both ways, response select and controller
`timescale 1ns/1ps

module dcache_top #(
  parameter int INDEX_BITS = dcache_pkg::DEF_INDEX_BITS
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  dcache_pkg::cpu_req_t cpu_req,
  output logic                 addr_ok,
  output logic                 data_ok,
  output logic [31:0]          rdata,
  output logic                 mem_rd_req,
  input  logic                 mem_rd_rdy,
  output logic [31:0]          mem_rd_addr,
  input  logic                 mem_ret_valid,
  input  dcache_pkg::line_t    mem_ret_data,
  output logic                 mem_wr_req,
  input  logic                 mem_wr_rdy,
  output logic [31:0]          mem_wr_addr,
  output dcache_pkg::line_t    mem_wr_data,
  input  logic                 mem_wr_done
);
  import dcache_pkg::*;

  localparam int TAG_BITS = 32 - OFFSET_BITS - INDEX_BITS;

  cpu_req_t                          req_q;
  logic [INDEX_BITS-1:0]             rd_index;
  logic [31:0]                       store_word;
  logic [3:0]                        store_strb;
  logic                              accept;
  logic [NUM_WAYS-1:0]               hit;
  line_t [NUM_WAYS-1:0]              lines;
  logic [NUM_WAYS-1:0][TAG_BITS-1:0] tags;
  logic [NUM_WAYS-1:0]               dirty;
  logic [NUM_WAYS-1:0]               way_sel;
  way_wr_t                           wr;
  logic                              hit_any;
  logic                              hit_way;
  logic [31:0]                       load_word;
  line_t                             victim_line;
  logic [TAG_BITS-1:0]               victim_tag;
  logic                              victim_dirty;
  logic                              victim_way;

  dcache_req_stage #(.INDEX_BITS(INDEX_BITS)) u_req_stage (
    .clk, .rst_n, .cpu_req, .accept, .req_q, .rd_index, .store_word, .store_strb
  );

  for (genvar i = 0; i < NUM_WAYS; i++) begin : g_way
    dcache_way #(.INDEX_BITS(INDEX_BITS)) u_way (
      .clk, .rst_n, .rd_index,
      .rd_tag  (req_q.addr[31 -: TAG_BITS]),
      .way_sel (way_sel[i]),
      .wr,
      .hit     (hit[i]),
      .line    (lines[i]),
      .tag_out (tags[i]),
      .dirty   (dirty[i])
    );
  end

  dcache_resp_sel #(.INDEX_BITS(INDEX_BITS)) u_resp_sel (
    .hit, .lines, .tags, .dirty,
    .word_sel (req_q.addr[3:2]),
    .victim_way, .hit_any, .hit_way, .load_word, .victim_line, .victim_tag, .victim_dirty
  );

  dcache_ctrl #(.INDEX_BITS(INDEX_BITS)) u_ctrl (
    .clk, .rst_n, .cpu_req, .req_q, .store_word, .store_strb,
    .hit_any, .hit_way, .load_word, .victim_line, .victim_tag, .victim_dirty,
    .mem_rd_rdy, .mem_ret_valid, .mem_ret_data, .mem_wr_rdy, .mem_wr_done,
    .accept, .addr_ok, .data_ok, .rdata, .victim_way, .way_sel, .wr,
    .mem_rd_req, .mem_rd_addr, .mem_wr_req, .mem_wr_addr, .mem_wr_data
  );

endmodule

// ==== rtl/dcache_way.sv ====
// one cache way
// tag, valid, dirty and data arrays with registered read,
// the hit compare and the fill or store write port
`timescale 1ns/1ps

module dcache_way #(
  parameter  int INDEX_BITS = 8,
  localparam int TAG_BITS   = 32 - dcache_pkg::OFFSET_BITS - INDEX_BITS
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [INDEX_BITS-1:0] rd_index,
  input  logic [TAG_BITS-1:0]   rd_tag,
  input  logic                  way_sel,
  input  dcache_pkg::way_wr_t   wr,
  output logic                  hit,
  output dcache_pkg::line_t     line,
  output logic [TAG_BITS-1:0]   tag_out,
  output logic                  dirty
);
  import dcache_pkg::*;

  localparam int SETS = 1 << INDEX_BITS;

  logic [TAG_BITS-1:0]   tag_mem [SETS];
  line_t                 data_mem [SETS];
  logic [SETS-1:0]       valid_bits;
  logic [SETS-1:0]       dirty_bits;
  logic                  valid_q;
  logic                  wr_en;
  logic [INDEX_BITS-1:0] wr_index;

  assign wr_en    = wr.en & way_sel;
  assign wr_index = wr.index[INDEX_BITS-1:0];

  // tag and data arrays
  always_ff @(posedge clk) begin
    if (wr_en && wr.fill) begin
      tag_mem[wr_index]  <= wr.tag[TAG_BITS-1:0];
      data_mem[wr_index] <= wr.line;
    end else if (wr_en) begin
      for (int b = 0; b < 4; b++) begin
        if (wr.strb[b]) begin
          data_mem[wr_index][wr.word_sel][8*b +: 8] <= wr.line[wr.word_sel][8*b +: 8];
        end
      end
    end
    tag_out <= tag_mem[rd_index];  // read before write on the same index
    line    <= data_mem[rd_index];
  end

  // valid and dirty bits
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_bits <= '0;
      dirty_bits <= '0;
      valid_q    <= 1'b0;
      dirty      <= 1'b0;
    end else begin
      if (wr_en) begin
        if (wr.fill) begin
          valid_bits[wr_index] <= 1'b1;
        end
        dirty_bits[wr_index] <= wr.set_dirty; // fill clears, store sets
      end
      valid_q <= valid_bits[rd_index];
      dirty   <= dirty_bits[rd_index];
    end
  end

  // tag of the request in lookup
  assign hit = valid_q && (tag_out == rd_tag);

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the data cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module tb_dcache -o sim_dcache
out=$(./obj_dir/sim_dcache)
echo "$out"

if echo "$out" | grep -q ">>> PASS"; then
  exit 0
fi
exit 1

// ==== test/dcache_checker.sv ====
// watches the cache ports against a shadow memory
// load data, refill address, writeback lines,
// refill and writeback counts per request
`timescale 1ns/1ps

module dcache_checker (
  input  logic                 clk,
  input  logic                 rst_n,
  input  dcache_pkg::cpu_req_t cpu_req,
  input  logic                 addr_ok,
  input  logic                 data_ok,
  input  logic [31:0]          rdata,
  input  logic                 mem_rd_req,
  input  logic                 mem_rd_rdy,
  input  logic [31:0]          mem_rd_addr,
  input  logic                 mem_wr_req,
  input  logic                 mem_wr_rdy,
  input  logic [31:0]          mem_wr_addr,
  input  dcache_pkg::line_t    mem_wr_data,
  input  int                   exp_rd,
  input  int                   exp_wr,
  input  int                   test_num,
  input  logic                 test_end,
  input  logic                 report,
  output int                   err_cnt
);
  import dcache_pkg::*;

  typedef struct {
    logic        op;
    logic [31:0] addr;
    logic [31:0] exp;
    int          exp_rd;
    int          exp_wr;
  } pend_t;

  line_t       shadow [1024];
  pend_t       pend [$];
  pend_t       e;
  integer      seed;
  int          rd_seen = 0;
  int          wr_seen = 0;
  int          checks = 0;
  int          test_reqs = 0;
  int          test_errs = 0;
  logic        rst_seen = 1'b0;
  logic [31:0] cur;
  logic [31:0] line_addr;

  // same fill sequence as the memory model
  initial begin
    seed = 32'h802b_821f;
    err_cnt = 0;
    for (int l = 0; l < 1024; l++) begin
      for (int w = 0; w < WORDS_PER_LINE; w++) begin
        shadow[l][w] = $random(seed);
      end
    end
  end

  // byte lanes written by a store of each size
  function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [1:0] ofs,
                                              input store_size_e size, input logic [31:0] wd);
    logic [31:0] w;
    w = old;
    for (int b = 0; b < 4; b++) begin
      if (size == size_word) begin
        w[8*b +: 8] = wd[8*b +: 8];
      end else if (size == size_half && (b / 2) == int'(ofs[1])) begin
        w[8*b +: 8] = wd[8*(b % 2) +: 8];
      end else if (size == size_byte && b == int'(ofs)) begin
        w[8*b +: 8] = wd[7:0];
      end
    end
    return w;
  endfunction

  task automatic note_error();
    err_cnt++;
    test_errs++;
  endtask

  always @(posedge clk) begin
    if (rst_n && !rst_seen) begin
      rst_seen = 1'b1;
      if (addr_ok || data_ok || mem_rd_req || mem_wr_req) begin
        $display("handshake or memory request is high right after reset");
        note_error();
      end
    end
    if (mem_wr_req && mem_wr_rdy) begin
      checks++;
      wr_seen++;
      if (mem_wr_data !== shadow[mem_wr_addr[13:4]]) begin
        $display("error t=%0t mem_wr_data expected %h got %h", $time,
                 shadow[mem_wr_addr[13:4]], mem_wr_data);
        note_error();
      end
    end
    if (mem_rd_req && mem_rd_rdy) begin
      rd_seen++;
      if (pend.size() == 0) begin
        $display("refill was requested with no request outstanding");
        note_error();
      end else begin
        checks++;
        line_addr = pend[0].addr & 32'hffff_fff0;  // 16-byte line
        if (mem_rd_addr !== line_addr) begin
          $display("error t=%0t mem_rd_addr expected %h got %h", $time,
                   line_addr, mem_rd_addr);
          note_error();
        end
        if (pend[0].exp_wr > 0 && wr_seen == 0) begin
          $display("refill was requested before the dirty line was written back");
          note_error();
        end
      end
    end
    if (data_ok) begin
      if (pend.size() == 0) begin
        $display("data_ok pulsed with no request outstanding");
        note_error();
      end else begin
        e = pend.pop_front();
        checks++;
        if (!e.op && rdata !== e.exp) begin
          $display("error t=%0t rdata expected %h got %h", $time, e.exp, rdata);
          note_error();
        end
        if (e.exp_rd >= 0 && rd_seen != e.exp_rd) begin
          $display("error t=%0t mem_rd_req count expected %0d got %0d", $time, e.exp_rd, rd_seen);
          note_error();
        end
        if (e.exp_wr >= 0 && wr_seen != e.exp_wr) begin
          $display("error t=%0t mem_wr_req count expected %0d got %0d", $time, e.exp_wr, wr_seen);
          note_error();
        end
      end
      rd_seen = 0;
      wr_seen = 0;
    end
    if (addr_ok && cpu_req.valid) begin  // accepted, shadow moves now
      cur = shadow[cpu_req.addr[13:4]][cpu_req.addr[3:2]];
      e.op     = cpu_req.op;
      e.addr   = cpu_req.addr;
      e.exp    = cur;
      e.exp_rd = exp_rd;
      e.exp_wr = exp_wr;
      pend.push_back(e);
      test_reqs++;
      if (cpu_req.op) begin
        shadow[cpu_req.addr[13:4]][cpu_req.addr[3:2]] =
          merge_store(cur, cpu_req.addr[1:0], cpu_req.size, cpu_req.wdata);
      end
    end
    if (test_end) begin
      $display("test %0d done: %0d requests, %0d errors", test_num, test_reqs, test_errs);
      test_reqs = 0;
      test_errs = 0;
    end
    if (report) begin
      $display("summary: %0d checks, %0d errors", checks, err_cnt);
    end
  end

endmodule

// ==== test/mem_model.sv ====
// line-wide memory model for the cache memory port
// random fill from a fixed seed, random ready and completion delays
`timescale 1ns/1ps

module mem_model (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              mem_rd_req,
  input  logic [31:0]       mem_rd_addr,
  output logic              mem_rd_rdy,
  output logic              mem_ret_valid,
  output dcache_pkg::line_t mem_ret_data,
  input  logic              mem_wr_req,
  input  logic [31:0]       mem_wr_addr,
  input  dcache_pkg::line_t mem_wr_data,
  output logic              mem_wr_rdy,
  output logic              mem_wr_done
);
  import dcache_pkg::*;

  localparam int LINES = 1024;  // 16 KiB, addr[13:4]

  line_t       mem [LINES];
  integer      seed;
  logic [31:0] rnd;
  logic [1:0]  rd_wait;
  logic [1:0]  wr_wait;
  logic        rd_busy;
  logic        wr_busy;
  logic [9:0]  rd_line;

  initial begin
    seed = 32'h802b_821f;
    mem_rd_rdy    <= 1'b0;
    mem_ret_valid <= 1'b0;
    mem_ret_data  <= '0;
    mem_wr_rdy    <= 1'b0;
    mem_wr_done   <= 1'b0;
    for (int l = 0; l < LINES; l++) begin
      for (int w = 0; w < WORDS_PER_LINE; w++) begin
        mem[l][w] = $random(seed);
      end
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      mem_rd_rdy    <= 1'b0;
      mem_ret_valid <= 1'b0;
      mem_ret_data  <= '0;
      mem_wr_rdy    <= 1'b0;
      mem_wr_done   <= 1'b0;
      rd_busy = 1'b0;
      wr_busy = 1'b0;
    end else begin
      mem_ret_valid <= 1'b0;
      mem_wr_done   <= 1'b0;
      // read channel
      if (mem_rd_req && mem_rd_rdy) begin
        rd_line = mem_rd_addr[13:4];
        rnd = $random(seed);
        rd_wait = rnd[1:0];
        rd_busy = 1'b1;
        mem_rd_rdy <= 1'b0;
      end else if (rd_busy) begin
        if (rd_wait == 2'd0) begin
          mem_ret_valid <= 1'b1;
          mem_ret_data  <= mem[rd_line];
          rd_busy = 1'b0;
        end else begin
          rd_wait = rd_wait - 2'd1;
        end
      end else begin
        rnd = $random(seed);
        mem_rd_rdy <= mem_rd_req & rnd[0];
      end
      // write channel, data lands at the handshake
      if (mem_wr_req && mem_wr_rdy) begin
        mem[mem_wr_addr[13:4]] = mem_wr_data;
        rnd = $random(seed);
        wr_wait = rnd[1:0];
        wr_busy = 1'b1;
        mem_wr_rdy <= 1'b0;
      end else if (wr_busy) begin
        if (wr_wait == 2'd0) begin
          mem_wr_done <= 1'b1;
          wr_busy = 1'b0;
        end else begin
          wr_wait = wr_wait - 2'd1;
        end
      end else begin
        rnd = $random(seed);
        mem_wr_rdy <= mem_wr_req & rnd[0];
      end
    end
  end

endmodule

// ==== test/tb_dcache.sv ====
// testbench for the two-way data cache
// clock, reset, stimulus table, DUT, memory model and checker
`timescale 1ns/1ps

module tb_dcache;
  import dcache_pkg::*;

  localparam int TIMEOUT = 500;

  typedef struct {
    int          test;
    logic        op;
    logic [31:0] addr;
    store_size_e size;
    logic [31:0] wdata;
    int          exp_rd;  // -1 when not checked
    int          exp_wr;
  } row_t;

  logic     clk = 1'b0;
  logic     rst_n;
  cpu_req_t cpu_req;
  logic     addr_ok, data_ok, mem_rd_req, mem_rd_rdy, mem_ret_valid;
  logic     mem_wr_req, mem_wr_rdy, mem_wr_done;
  logic [31:0] rdata, mem_rd_addr, mem_wr_addr;
  line_t    mem_ret_data, mem_wr_data;
  int       exp_rd, exp_wr, test_num, err_cnt;
  logic     test_end, report;
  row_t     rows [$];
  integer   seed;
  logic     hung = 1'b0;

  always #5 clk = ~clk;

  dcache_top #(.INDEX_BITS(8)) dut_i (.*);

  mem_model mem_i (.*);

  dcache_checker chk_i (.*);

  function automatic void add_row(input int test, input logic op, input logic [31:0] addr,
                                  input store_size_e size, input logic [31:0] wdata,
                                  input int rd, input int wr);
    rows.push_back('{test, op, addr, size, wdata, rd, wr});
  endfunction

  // one request, held until accepted, then waits for its data_ok
  task automatic issue(input row_t r);
    int waited;
    cpu_req.valid <= 1'b1;
    cpu_req.op    <= r.op;
    cpu_req.addr  <= r.addr;
    cpu_req.size  <= r.size;
    cpu_req.wdata <= r.wdata;
    exp_rd        <= r.exp_rd;
    exp_wr        <= r.exp_wr;
    waited = 0;
    @(posedge clk);
    while (!addr_ok && !hung) begin
      waited++;
      if (waited == TIMEOUT) begin
        $display("request at %h was never accepted", r.addr);
        hung = 1'b1;
      end
      @(posedge clk);
    end
    cpu_req.valid <= 1'b0;
    waited = 0;
    @(posedge clk);
    while (!data_ok && !hung) begin
      waited++;
      if (waited == TIMEOUT) begin
        $display("request at %h never completed", r.addr);
        hung = 1'b1;
      end
      @(posedge clk);
    end
  endtask

  initial begin
    logic [31:0] rnd;
    logic [1:0]  ofs;
    store_size_e size;
    seed = 32'h802b_821f;
    cpu_req  <= '0;
    rst_n    <= 1'b0;
    exp_rd   <= -1;
    exp_wr   <= -1;
    test_num <= 0;
    test_end <= 1'b0;
    report   <= 1'b0;
    add_row(1, 1'b0, 32'h0000_0040, size_word, 32'h0, 1, 0);   // cold miss
    add_row(2, 1'b0, 32'h0000_0044, size_word, 32'h0, 0, 0);   // same line
    add_row(3, 1'b1, 32'h0000_0080, size_word, 32'h1122_3344, 1, 0);
    add_row(3, 1'b1, 32'h0000_0082, size_half, 32'h0000_beef, 0, 0);
    add_row(3, 1'b1, 32'h0000_0081, size_byte, 32'h0000_005a, 0, 0);
    add_row(3, 1'b0, 32'h0000_0080, size_word, 32'h0, 0, 0);
    add_row(4, 1'b0, 32'h0000_0050, size_word, 32'h0, 1, 0);   // A
    add_row(4, 1'b0, 32'h0000_1050, size_word, 32'h0, 1, 0);   // B
    add_row(4, 1'b0, 32'h0000_0054, size_word, 32'h0, 0, 0);   // touch A
    add_row(4, 1'b0, 32'h0000_2050, size_word, 32'h0, 1, 0);   // C evicts B
    add_row(4, 1'b0, 32'h0000_0058, size_word, 32'h0, 0, 0);
    add_row(5, 1'b1, 32'h0000_0090, size_word, 32'hcafe_f00d, 1, 0);
    add_row(5, 1'b0, 32'h0000_1090, size_word, 32'h0, 1, 0);
    add_row(5, 1'b0, 32'h0000_2090, size_word, 32'h0, 1, 1);   // dirty A out
    add_row(5, 1'b0, 32'h0000_0090, size_word, 32'h0, 1, 0);
    for (int i = 0; i < 40; i++) begin
      rnd  = $random(seed);
      size = store_size_e'((rnd[1:0] == 2'd3) ? 2'd2 : rnd[1:0]);
      ofs  = (size == size_word) ? 2'd0 : (size == size_half) ? {rnd[11], 1'b0} : rnd[11:10];
      add_row(6, rnd[12], {18'd0, rnd[5:4], 6'd0, rnd[7:6], rnd[9:8], ofs}, size,
              $random(seed), -1, -1);
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    for (int i = 0; i < rows.size() && !hung; i++) begin
      issue(rows[i]);
      if (!hung && (i == rows.size() - 1 || rows[i + 1].test != rows[i].test)) begin
        test_num <= rows[i].test;
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
      end
    end
    report <= 1'b1;
    @(posedge clk);
    report <= 1'b0;
    @(posedge clk);
    if (!hung && err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
